// File: design/smpc_pkg.sv
package smpc_pkg;

	typedef logic [7:0]  byte_t;
	typedef logic [4:0]  oreg_addr_t;
	typedef logic [7:0]  bcd_t;
	typedef logic [15:0] year_t;
	typedef logic [3:0]  nib_t;
	typedef logic [15:0] wait_t;

	typedef enum logic [7:0] {
		CMD_MSHON   = 8'h00,
		CMD_SSHON   = 8'h02,
		CMD_SSHOFF  = 8'h03,
		CMD_SNDON   = 8'h06,
		CMD_SNDOFF  = 8'h07,
		CMD_CDON    = 8'h08,
		CMD_CDOFF   = 8'h09,
		CMD_INTBACK = 8'h10,
		CMD_SETTIME = 8'h16,
		CMD_NMIREQ  = 8'h18,
		CMD_RESENAB = 8'h19,
		CMD_RESDISA = 8'h1A
	} cmd_t;

	typedef enum logic [2:0] {
		IDLE,
		WAIT,
		COMMAND,
		EXEC,
		END
	} cmd_state_t;

	// Byte addresses on the host bus, always odd
	localparam logic [6:0] ADDR_IREG0  = 7'h01;
	localparam logic [6:0] ADDR_COMREG = 7'h1F;
	localparam logic [6:0] ADDR_OREG0  = 7'h21;
	localparam logic [6:0] ADDR_OREG31 = 7'h5F;
	localparam logic [6:0] ADDR_SR     = 7'h61;
	localparam logic [6:0] ADDR_SF     = 7'h63;

	localparam wait_t WAIT_ACCEPT  = 16'd60;
	localparam wait_t WAIT_POWER   = 16'd60;
	localparam wait_t WAIT_CD      = 16'd100;
	localparam wait_t WAIT_RES     = 16'd70;
	localparam wait_t WAIT_SETTIME = 16'd220;
	localparam wait_t WAIT_INTBACK = 16'd800;

	localparam int unsigned OREG_STATUS_LEN = 16;
	localparam oreg_addr_t  OREG_ECHO       = 5'd31;

	function automatic wait_t exec_wait(cmd_t c);
		case (c)
			CMD_MSHON, CMD_SSHON, CMD_SSHOFF, CMD_SNDON, CMD_SNDOFF: return WAIT_POWER;
			CMD_CDON, CMD_CDOFF:                  return WAIT_CD;
			CMD_NMIREQ, CMD_RESENAB, CMD_RESDISA: return WAIT_RES;
			CMD_SETTIME:                          return WAIT_SETTIME;
			CMD_INTBACK:                          return WAIT_INTBACK;
			default:                              return '0; // Unknown code
		endcase
	endfunction

endpackage

// File: design/smpc_ifs.sv
interface smpc_cmd_if import smpc_pkg::*; ();

	cmd_t  comreg;
	logic  comreg_set;
	byte_t ireg [7];
	logic  cmd_done;
	byte_t sr_status;

	modport host (
		output comreg, comreg_set, ireg,
		input  cmd_done, sr_status
	);

	modport seq (
		input  comreg, comreg_set, ireg,
		output cmd_done, sr_status
	);

	modport rtc (
		input  ireg
	);

endinterface

interface smpc_rtc_if import smpc_pkg::*; ();

	bcd_t  sec;
	bcd_t  min;
	bcd_t  hour;
	bcd_t  days;
	nib_t  day;
	nib_t  month;
	year_t year;
	logic  time_load;

	modport rtc (output sec, min, hour, days, day, month, year, input time_load);
	modport seq (input sec, min, hour, days, day, month, year, output time_load);

endinterface

// File: design/smpc_oreg_ram.sv
module smpc_oreg_ram import smpc_pkg::*; (
	input  logic       CLK,
	input  oreg_addr_t wr_addr,
	input  byte_t      wr_data,
	input  logic       wr_en,
	input  oreg_addr_t rd_addr,
	output byte_t      rd_data
);

	byte_t mem [32];

	always_ff @(posedge CLK) begin
		if (wr_en) mem[wr_addr] <= wr_data;
	end

	assign rd_data = mem[rd_addr]; // Host read is registered upstream

endmodule

// File: design/smpc_host_regs.sv
module smpc_host_regs import smpc_pkg::*; (
	input  logic       CLK,
	input  logic       RST_N,
	input  logic [6:1] A,
	input  byte_t      DI,
	output byte_t      DO,
	input  logic       CS_N,
	input  logic       RW_N,
	smpc_cmd_if.host   cmd,
	output oreg_addr_t rd_addr,
	input  byte_t      rd_data
);

	logic [6:0] byte_addr;
	logic [6:0] oreg_off;
	logic [6:0] ireg_off;
	logic       rw_n_old;
	logic       cs_n_old;
	logic       wr_stb;
	logic       rd_stb;
	logic       sf;

	assign byte_addr = {A, 1'b1};
	assign oreg_off  = byte_addr - ADDR_OREG0;
	assign ireg_off  = byte_addr - ADDR_IREG0;
	assign rd_addr   = oreg_off[5:1]; // Word address minus 10

	assign wr_stb = !RW_N && rw_n_old && !CS_N;
	assign rd_stb = !CS_N && cs_n_old && RW_N;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			rw_n_old <= 1'b1;
			cs_n_old <= 1'b1;
			cmd.ireg <= '{default: '0};
			cmd.comreg <= CMD_MSHON;
			cmd.comreg_set <= 1'b0;
			sf <= 1'b0;
			DO <= '0;
		end else begin
			rw_n_old <= RW_N;
			cs_n_old <= CS_N;
			cmd.comreg_set <= 1'b0;

			if (cmd.cmd_done) sf <= 1'b0;

			// A host write of SF wins over a finishing command
			if (wr_stb) begin
				if (byte_addr <= ADDR_IREG0 + 7'd12) begin // IREG0..IREG6
					cmd.ireg[ireg_off[3:1]] <= DI;
				end else if (byte_addr == ADDR_COMREG) begin
					cmd.comreg <= cmd_t'(DI);
					cmd.comreg_set <= 1'b1;
				end else if (byte_addr == ADDR_SF && DI[0]) begin
					sf <= 1'b1;
				end
			end

			if (rd_stb) begin
				if (byte_addr <= ADDR_OREG31)
					DO <= rd_data;
				else if (byte_addr == ADDR_SR)
					DO <= cmd.sr_status;
				else if (byte_addr == ADDR_SF)
					DO <= {7'b1111000, sf};
				else
					DO <= '0;
			end
		end
	end

endmodule

// File: design/smpc_command.sv
module smpc_command import smpc_pkg::*; (
	input  logic       CLK,
	input  logic       RST_N,
	input  logic       CE,
	input  nib_t       AC,
	smpc_cmd_if.seq    cmd,
	smpc_rtc_if.seq    rtc,
	output oreg_addr_t wr_addr,
	output byte_t      wr_data,
	output logic       wr_en,
	output logic       MSHRES_N,
	output logic       MSHNMI_N,
	output logic       SSHRES_N,
	output logic       SSHNMI_N,
	output logic       SNDRES_N,
	output logic       CDRES_N,
	output logic       MIRQ_N
);

	cmd_state_t state;
	cmd_state_t wait_next;
	wait_t      wait_cnt;
	logic       pend;
	oreg_addr_t oreg_cnt;
	logic       resd;
	logic       ste;
	byte_t      sr;
	byte_t      status_byte;

	assign cmd.sr_status = sr;
	assign cmd.cmd_done  = CE && (state == END);

	always_comb begin
		status_byte = 8'h00;
		if (oreg_cnt == OREG_ECHO) begin
			status_byte = cmd.comreg;
		end else if (oreg_cnt < OREG_STATUS_LEN) begin
			case (oreg_cnt)
				5'd0:    status_byte = {ste, resd, 6'b000000};
				5'd1:    status_byte = rtc.year[15:8];
				5'd2:    status_byte = rtc.year[7:0];
				5'd3:    status_byte = {rtc.day, rtc.month};
				5'd4:    status_byte = rtc.days;
				5'd5:    status_byte = rtc.hour;
				5'd6:    status_byte = rtc.min;
				5'd7:    status_byte = rtc.sec;
				5'd9:    status_byte = {4'b0000, AC};
				5'd10:   status_byte = {4'b0011, ~MSHNMI_N, 2'b11, ~SNDRES_N};
				5'd11:   status_byte = {1'b0, ~CDRES_N, 6'b000000};
				default: status_byte = 8'h00; // SMEM bytes read zero
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (CE && state == EXEC) begin
			if (cmd.comreg == CMD_INTBACK) begin
				wr_addr <= oreg_cnt;
				wr_data <= status_byte;
			end else begin
				wr_addr <= OREG_ECHO;
				wr_data <= cmd.comreg;
			end
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state <= IDLE;
			wait_next <= IDLE;
			wait_cnt <= '0;
			pend <= 1'b0;
			oreg_cnt <= '0;
			wr_en <= 1'b0;
			rtc.time_load <= 1'b0;
			MSHRES_N <= 1'b1;
			MSHNMI_N <= 1'b1;
			SSHRES_N <= 1'b0;
			SSHNMI_N <= 1'b1;
			SNDRES_N <= 1'b0;
			CDRES_N <= 1'b1;
			MIRQ_N <= 1'b1;
			resd <= 1'b1;
			ste <= 1'b0;
			sr <= '0;
		end else begin
			wr_en <= 1'b0;
			rtc.time_load <= 1'b0;

			if (CE) begin
				case (state)
					IDLE: begin
						MIRQ_N <= 1'b1;
						if (pend) begin
							pend <= 1'b0;
							oreg_cnt <= '0;
							wait_cnt <= WAIT_ACCEPT;
							wait_next <= COMMAND;
							state <= WAIT;
						end
					end

					WAIT: begin
						if (wait_cnt == '0)
							state <= wait_next;
						else
							wait_cnt <= wait_cnt - 16'd1;
					end

					COMMAND: begin
						if (cmd.comreg == CMD_INTBACK && !cmd.ireg[0][0]) begin
							state <= END; // No status requested
						end else if (exec_wait(cmd.comreg) == '0) begin
							state <= EXEC;
						end else begin
							wait_cnt <= exec_wait(cmd.comreg);
							wait_next <= EXEC;
							state <= WAIT;
						end
					end

					EXEC: begin
						wr_en <= 1'b1;
						state <= END;
						case (cmd.comreg)
							CMD_MSHON: begin
								MSHRES_N <= 1'b1;
								MSHNMI_N <= 1'b1;
							end
							CMD_SSHON: begin
								SSHRES_N <= 1'b1;
								SSHNMI_N <= 1'b1;
							end
							CMD_SSHOFF: begin
								SSHRES_N <= 1'b0;
								SSHNMI_N <= 1'b1;
							end
							CMD_SNDON:   SNDRES_N <= 1'b1;
							CMD_SNDOFF:  SNDRES_N <= 1'b0;
							CMD_CDON:    CDRES_N <= 1'b1;
							CMD_CDOFF:   CDRES_N <= 1'b0;
							CMD_NMIREQ:  MSHNMI_N <= 1'b0; // Released in END
							CMD_RESENAB: resd <= 1'b0;
							CMD_RESDISA: resd <= 1'b1;
							CMD_SETTIME: begin
								rtc.time_load <= 1'b1;
								ste <= 1'b1;
							end
							CMD_INTBACK: begin
								oreg_cnt <= oreg_cnt + 5'd1;
								if (oreg_cnt == OREG_ECHO) begin
									sr <= 8'h4F;
									MIRQ_N <= 1'b0;
								end else begin
									state <= EXEC; // One OREG byte per cycle
								end
							end
							default: ;
						endcase
					end

					END: begin
						if (cmd.comreg == CMD_NMIREQ) MSHNMI_N <= 1'b1;
						state <= IDLE;
					end

					default: state <= IDLE;
				endcase
			end

			// Held until the sequencer is back in IDLE
			if (cmd.comreg_set) pend <= 1'b1;
		end
	end

endmodule

// File: design/smpc_rtc.sv
module smpc_rtc import smpc_pkg::*; #(
	parameter int unsigned TICKS_PER_SEC = 4000000
) (
	input  logic    CLK,
	input  logic    RST_N,
	input  logic    CE,
	smpc_cmd_if.rtc cmd,
	smpc_rtc_if.rtc rtc
);

	localparam int unsigned PRE_W = $clog2(TICKS_PER_SEC + 1);

	logic [PRE_W-1:0] pre_cnt;
	logic             sec_tick;
	logic             min_tick;
	logic             hour_tick;
	logic             day_tick;
	logic             mon_tick;
	logic             year_tick;

	function automatic bcd_t bcd_inc(bcd_t v);
		if (v[3:0] == 4'd9)
			return {v[7:4] + 4'd1, 4'd0};
		return {v[7:4], v[3:0] + 4'd1};
	endfunction

	// No leap years
	function automatic bcd_t last_day(nib_t m);
		case (m)
			4'd2:                     return 8'h28;
			4'd4, 4'd6, 4'd9, 4'd11:  return 8'h30;
			default:                  return 8'h31;
		endcase
	endfunction

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			pre_cnt <= '0;
			{sec_tick, min_tick, hour_tick, day_tick, mon_tick, year_tick} <= '0;
			rtc.sec <= 8'h00;
			rtc.min <= 8'h00;
			rtc.hour <= 8'h00;
			rtc.days <= 8'h01;
			rtc.day <= 4'h2;
			rtc.month <= 4'h1;
			rtc.year <= 16'h2024;
		end else if (rtc.time_load) begin
			{sec_tick, min_tick, hour_tick, day_tick, mon_tick, year_tick} <= '0;
			rtc.sec <= cmd.ireg[6];
			rtc.min <= cmd.ireg[5];
			rtc.hour <= cmd.ireg[4];
			rtc.days <= cmd.ireg[3];
			{rtc.day, rtc.month} <= cmd.ireg[2];
			rtc.year <= {cmd.ireg[0], cmd.ireg[1]};
		end else if (CE) begin
			{sec_tick, min_tick, hour_tick, day_tick, mon_tick, year_tick} <= '0;

			if (pre_cnt == PRE_W'(TICKS_PER_SEC - 1)) begin
				pre_cnt <= '0;
				sec_tick <= 1'b1;
			end else begin
				pre_cnt <= pre_cnt + 1'b1;
			end

			// Carries ripple one field per cycle
			if (sec_tick) begin
				if (rtc.sec == 8'h59) begin
					rtc.sec <= 8'h00;
					min_tick <= 1'b1;
				end else begin
					rtc.sec <= bcd_inc(rtc.sec);
				end
			end
			if (min_tick) begin
				if (rtc.min == 8'h59) begin
					rtc.min <= 8'h00;
					hour_tick <= 1'b1;
				end else begin
					rtc.min <= bcd_inc(rtc.min);
				end
			end
			if (hour_tick) begin
				if (rtc.hour == 8'h23) begin
					rtc.hour <= 8'h00;
					day_tick <= 1'b1;
				end else begin
					rtc.hour <= bcd_inc(rtc.hour);
				end
			end
			if (day_tick) begin
				if (rtc.days == last_day(rtc.month)) begin
					rtc.days <= 8'h01;
					mon_tick <= 1'b1;
				end else begin
					rtc.days <= bcd_inc(rtc.days);
				end
			end
			if (mon_tick) begin
				if (rtc.month == 4'd12) begin
					rtc.month <= 4'd1;
					year_tick <= 1'b1;
				end else begin
					rtc.month <= rtc.month + 4'd1;
				end
			end
			if (year_tick) rtc.year <= rtc.year + 16'd1; // Binary step
		end
	end

endmodule

// File: design/smpc_top.sv
module smpc_top import smpc_pkg::*; #(
	parameter int unsigned TICKS_PER_SEC = 4000000
) (
	input  logic       CLK,
	input  logic       RST_N,
	input  logic       CE,
	input  logic [6:1] A,
	input  byte_t      DI,
	output byte_t      DO,
	input  logic       CS_N,
	input  logic       RW_N,
	input  nib_t       AC,
	output logic       MSHRES_N,
	output logic       MSHNMI_N,
	output logic       SSHRES_N,
	output logic       SSHNMI_N,
	output logic       SNDRES_N,
	output logic       CDRES_N,
	output logic       MIRQ_N
);

	oreg_addr_t wr_addr;
	byte_t      wr_data;
	logic       wr_en;
	oreg_addr_t rd_addr;
	byte_t      rd_data;

	smpc_cmd_if cmd_if ();
	smpc_rtc_if rtc_if ();

	smpc_host_regs u_host (
		.CLK     (CLK),
		.RST_N   (RST_N),
		.A       (A),
		.DI      (DI),
		.DO      (DO),
		.CS_N    (CS_N),
		.RW_N    (RW_N),
		.cmd     (cmd_if.host),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	smpc_command u_seq (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.CE       (CE),
		.AC       (AC),
		.cmd      (cmd_if.seq),
		.rtc      (rtc_if.seq),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data),
		.wr_en    (wr_en),
		.MSHRES_N (MSHRES_N),
		.MSHNMI_N (MSHNMI_N),
		.SSHRES_N (SSHRES_N),
		.SSHNMI_N (SSHNMI_N),
		.SNDRES_N (SNDRES_N),
		.CDRES_N  (CDRES_N),
		.MIRQ_N   (MIRQ_N)
	);

	smpc_rtc #(
		.TICKS_PER_SEC (TICKS_PER_SEC)
	) u_rtc (
		.CLK   (CLK),
		.RST_N (RST_N),
		.CE    (CE),
		.cmd   (cmd_if.rtc),
		.rtc   (rtc_if.rtc)
	);

	smpc_oreg_ram u_oreg (
		.CLK     (CLK),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.wr_en   (wr_en),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

endmodule

// File: verif/smpc_tests.svh
task automatic test_reset();
	byte_t val;
	check_eq(MSHRES_N, 1'b1, "MSHRES_N after reset");
	check_eq(MSHNMI_N, 1'b1, "MSHNMI_N after reset");
	check_eq(SSHRES_N, 1'b0, "SSHRES_N after reset");
	check_eq(SSHNMI_N, 1'b1, "SSHNMI_N after reset");
	check_eq(SNDRES_N, 1'b0, "SNDRES_N after reset");
	check_eq(CDRES_N, 1'b1, "CDRES_N after reset");
	check_eq(MIRQ_N, 1'b1, "MIRQ_N after reset");
	bus_read(ADDR_SR, val);
	check_eq(val, 8'h00, "SR after reset");
	bus_read(ADDR_SF, val);
	check_eq(val, 8'hF0, "SF after reset");
endtask

task automatic test_power();
	run_cmd(CMD_MSHON);
	check_eq(MSHRES_N, 1'b1, "MSHON releases MSHRES_N");
	check_oreg(31, CMD_MSHON, "MSHON echo");
	run_cmd(CMD_SSHON);
	check_eq(SSHRES_N, 1'b1, "SSHON sets SSHRES_N");
	check_oreg(31, CMD_SSHON, "SSHON echo");
	run_cmd(CMD_SNDON);
	check_eq(SNDRES_N, 1'b1, "SNDON sets SNDRES_N");
	check_oreg(31, CMD_SNDON, "SNDON echo");
	run_cmd(CMD_CDOFF);
	check_eq(CDRES_N, 1'b0, "CDOFF clears CDRES_N");
	check_oreg(31, CMD_CDOFF, "CDOFF echo");
	run_cmd(CMD_CDON);
	check_eq(CDRES_N, 1'b1, "CDON sets CDRES_N");
	check_oreg(31, CMD_CDON, "CDON echo");
	run_cmd(CMD_SSHOFF);
	check_eq(SSHRES_N, 1'b0, "SSHOFF clears SSHRES_N");
	check_oreg(31, CMD_SSHOFF, "SSHOFF echo");
	run_cmd(CMD_SNDOFF);
	check_eq(SNDRES_N, 1'b0, "SNDOFF clears SNDRES_N");
	check_oreg(31, CMD_SNDOFF, "SNDOFF echo");
	run_cmd(8'h05); // Not a kept code
	check_oreg(31, 8'h05, "unknown code echo");
endtask

task automatic test_nmi();
	nmi_seen = 1'b0;
	run_cmd(CMD_NMIREQ);
	check_eq(nmi_seen, 1'b1, "MSHNMI_N low while NMIREQ runs");
	check_eq(MSHNMI_N, 1'b1, "MSHNMI_N released after NMIREQ");
	check_oreg(31, CMD_NMIREQ, "NMIREQ echo");
endtask

task automatic test_resd_intback();
	byte_t val;
	rng = xorshift(rng);
	@(negedge CLK);
	AC = rng[3:0];
	bus_write(ADDR_IREG0, 8'h01); // Status part requested
	run_cmd(CMD_RESENAB);
	irq_seen = 1'b0;
	run_cmd(CMD_INTBACK);
	check_eq(irq_seen, 1'b1, "MIRQ_N pulse after INTBACK");
	check_eq(MIRQ_N, 1'b1, "MIRQ_N released after INTBACK");
	read_oreg(0, val);
	check_eq(val[6], 1'b0, "RESD after RESENAB");
	check_eq(val[7], 1'b0, "STE before SETTIME");
	bus_read(ADDR_SR, val);
	check_eq(val, 8'h4F, "SR after INTBACK");
	check_oreg(9, {4'h0, AC}, "OREG9 holds AC");
	// NMI released, sound CPU held, CD running
	check_oreg(10, 8'h37, "OREG10 flags");
	check_oreg(11, 8'h00, "OREG11 flags");
	for (int i = 12; i < 16; i++)
		check_oreg(i, 8'h00, "SMEM byte");
	check_oreg(31, CMD_INTBACK, "INTBACK echo");
	run_cmd(CMD_RESDISA);
	run_cmd(CMD_INTBACK);
	read_oreg(0, val);
	check_eq(val[6], 1'b1, "RESD after RESDISA");
endtask

task automatic load_time(input bcd_t min, input bcd_t sec, input nib_t wd);
	bus_write(ADDR_IREG0, 8'h19);
	bus_write(ADDR_IREG0 + 7'd2, 8'h99);
	bus_write(ADDR_IREG0 + 7'd4, {wd, 4'hC});
	bus_write(ADDR_IREG0 + 7'd6, 8'h31);
	bus_write(ADDR_IREG0 + 7'd8, 8'h23);
	bus_write(ADDR_IREG0 + 7'd10, min);
	bus_write(ADDR_IREG0 + 7'd12, sec);
endtask

task automatic wait_seconds(input int n);
	repeat (n * TICKS_PER_SEC) @(negedge CLK);
endtask

task automatic test_settime();
	byte_t val;
	nib_t  wd;
	rng = xorshift(rng);
	wd = nib_t'(rng % 7);
	// INTBACK alone takes over 4 s here, so the minute must start fresh
	load_time(8'h59, 8'h00, wd);
	run_cmd(CMD_SETTIME);
	bus_write(ADDR_IREG0, 8'h01);
	run_cmd(CMD_INTBACK);
	read_oreg(0, val);
	check_eq(val[7], 1'b1, "STE after SETTIME");
	check_oreg(1, 8'h19, "year high before rollover");
	check_oreg(2, 8'h99, "year low before rollover");
	check_oreg(3, {wd, 4'hC}, "weekday and month before rollover");
	check_oreg(4, 8'h31, "days before rollover");
	check_oreg(5, 8'h23, "hours before rollover");
	check_oreg(6, 8'h59, "minutes before rollover");

	load_time(8'h59, 8'h58, wd);
	run_cmd(CMD_SETTIME);
	repeat (2) wait_seconds(2);
	bus_write(ADDR_IREG0, 8'h01);
	run_cmd(CMD_INTBACK);
	check_oreg(1, 8'h19, "year high after rollover");
	check_oreg(2, 8'h9A, "year low after rollover"); // Year steps in binary
	check_oreg(3, {wd, 4'h1}, "weekday and month after rollover");
	check_oreg(4, 8'h01, "days after rollover");
	check_oreg(5, 8'h00, "hours after rollover");
	check_oreg(6, 8'h00, "minutes after rollover");
endtask

// File: verif/smpc_tb.sv
module smpc_tb import smpc_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int unsigned TICKS_PER_SEC = 200;
	localparam longint unsigned CLK_PERIOD = 100;
	// About 40 commands of at most 5000 cycles each, second waits included
	localparam longint unsigned MAX_CMDS = 40;
	localparam longint unsigned CMD_CYCLES = 5000;
	localparam longint unsigned TIMEOUT_NS = MAX_CMDS * CMD_CYCLES * CLK_PERIOD;

	logic       CLK;
	logic       RST_N;
	logic       CE;
	logic [6:1] A;
	byte_t      DI;
	byte_t      DO;
	logic       CS_N;
	logic       RW_N;
	nib_t       AC;
	logic       MSHRES_N;
	logic       MSHNMI_N;
	logic       SSHRES_N;
	logic       SSHNMI_N;
	logic       SNDRES_N;
	logic       CDRES_N;
	logic       MIRQ_N;

	logic [31:0] rng;
	logic        busy;
	logic        nmi_seen;
	logic        irq_seen;

	smpc_top #(
		.TICKS_PER_SEC (TICKS_PER_SEC)
	) dut0 (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.CE       (CE),
		.A        (A),
		.DI       (DI),
		.DO       (DO),
		.CS_N     (CS_N),
		.RW_N     (RW_N),
		.AC       (AC),
		.MSHRES_N (MSHRES_N),
		.MSHNMI_N (MSHNMI_N),
		.SSHRES_N (SSHRES_N),
		.SSHNMI_N (SSHNMI_N),
		.SNDRES_N (SNDRES_N),
		.CDRES_N  (CDRES_N),
		.MIRQ_N   (MIRQ_N)
	);

	always #(CLK_PERIOD / 2) CLK = ~CLK;

	// NMI and IRQ pulses are too short for bus polling
	always @(negedge CLK) begin
		if (busy && !MSHNMI_N) nmi_seen = 1'b1;
		if (busy && !MIRQ_N) irq_seen = 1'b1;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("** FAIL **");
		$fatal(1, "Watchdog timeout after %0d ns, the tests did not finish", TIMEOUT_NS);
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("ERROR @ %0t ns: %s: got %0h, expected %0h", $time, what, got, exp);
			$display("** FAIL **");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	// Write strobe is the falling RW_N while CS_N is low
	task automatic bus_write(input logic [6:0] addr, input byte_t data);
		@(negedge CLK);
		A = addr[6:1];
		DI = data;
		CS_N = 1'b0;
		@(negedge CLK);
		RW_N = 1'b0;
		@(negedge CLK);
		RW_N = 1'b1;
		CS_N = 1'b1;
	endtask

	task automatic bus_read(input logic [6:0] addr, output byte_t data);
		@(negedge CLK);
		A = addr[6:1];
		RW_N = 1'b1;
		CS_N = 1'b0;
		@(negedge CLK);
		data = DO; // Loaded on the edge after CS_N fell
		CS_N = 1'b1;
	endtask

	task automatic read_oreg(input int idx, output byte_t data);
		bus_read(ADDR_OREG0 + 7'(2 * idx), data);
	endtask

	task automatic check_oreg(input int idx, input byte_t exp, input string what);
		byte_t val;
		read_oreg(idx, val);
		check_eq(val, exp, what);
	endtask

	task automatic run_cmd(input byte_t code);
		byte_t sf_val;
		int    polls;
		busy = 1'b1;
		bus_write(ADDR_SF, 8'h01);
		bus_write(ADDR_COMREG, code);
		bus_read(ADDR_SF, sf_val);
		check_eq(sf_val, 8'hF1, "SF set while command runs");
		polls = 0;
		while (sf_val != 8'hF0 && polls < 2000) begin
			bus_read(ADDR_SF, sf_val);
			polls++;
		end
		busy = 1'b0;
		if (sf_val != 8'hF0) begin
			$display("** FAIL **");
			$fatal(1, "SF still set after 2000 polls of command %02h", code);
		end
	endtask

	`include "smpc_tests.svh"

	initial begin
		CLK = 1'b0;
		RST_N = 1'b0;
		CE = 1'b1;
		A = '0;
		DI = '0;
		CS_N = 1'b1;
		RW_N = 1'b1;
		AC = '0;
		rng = 32'h09f2_15e3;
		busy = 1'b0;
		nmi_seen = 1'b0;
		irq_seen = 1'b0;
		repeat (8) @(negedge CLK);
		RST_N = 1'b1;

		test_reset();
		test_power();
		test_nmi();
		test_resd_intback();
		test_settime();

		$display("** PASS **");
		$finish;
	end

endmodule

// File: filelist.f
+incdir+verif
design/smpc_pkg.sv
design/smpc_ifs.sv
design/smpc_oreg_ram.sv
design/smpc_host_regs.sv
design/smpc_command.sv
design/smpc_rtc.sv
design/smpc_top.sv
verif/smpc_tb.sv

// File: Bender.yml
package:
  name: smpc

sources:
  - design/smpc_pkg.sv
  - design/smpc_ifs.sv
  - design/smpc_oreg_ram.sv
  - design/smpc_host_regs.sv
  - design/smpc_command.sv
  - design/smpc_rtc.sv
  - design/smpc_top.sv
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/smpc_tb.sv
